//--- Bender.yml
package:
  name: icache

sources:
  - design/icache_pkg.sv
  - design/icache_lookup_if.sv
  - design/icache_tag_array.sv
  - design/icache_data_array.sv
  - design/icache_lru.sv
  - design/icache_refill_buf.sv
  - design/icache_ctrl.sv
  - design/icache.sv
  - target: simulation
    files:
      - sim/axi_line_mem.sv
      - sim/icache_tb.sv

//--- build.f
design/icache_pkg.sv
design/icache_lookup_if.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_lru.sv
design/icache_refill_buf.sv
design/icache_ctrl.sv
design/icache.sv
sim/axi_line_mem.sv
sim/icache_tb.sv

//--- design/icache.sv
`default_nettype none

module icache (
    input  logic                            clk,
    input  logic                            rst,
    // fetch side
    input  logic                            valid,
    input  logic [31:0]                     pc_in,
    input  logic [icache_pkg::COOKIE_W-1:0] cookie_in,
    output logic                            data_valid,
    output logic [icache_pkg::FETCH_W-1:0]  r_data_cpu,
    output logic [31:0]                     pc_out,
    output logic [icache_pkg::COOKIE_W-1:0] cookie_out,
    // line read port
    output logic                            r_req,
    output logic                            r_data_ready,
    output logic [31:0]                     r_addr,
    input  logic                            r_rdy,
    input  logic                            ret_valid,
    input  logic                            ret_last,
    input  logic [icache_pkg::BEAT_W-1:0]   r_data_axi,
    output logic [icache_pkg::EXC_W-1:0]    exception
);

    logic                           lookup_en;
    logic                           fill_we;
    logic [1:0]                     fill_way;
    logic [icache_pkg::INDEX_W-1:0] fill_index;
    logic [icache_pkg::TAG_W-1:0]   fill_tag;
    logic [icache_pkg::LINE_W-1:0]  fill_line;
    logic                           fill_finish;
    logic                           touch;
    logic [icache_pkg::INDEX_W-1:0] touch_index;
    logic [1:0]                     touch_way;
    logic [1:0]                     victim_way;

    icache_lookup_if lk ();             // stage 1 to stage 2

    // stage 1 arrays
    icache_tag_array tag_array (.*);

    icache_data_array data_array (.*);

    // beside stage 2
    icache_lru lru (.*);

    icache_refill_buf refill_buf (.*);

    // stage 2
    icache_ctrl ctrl (.*);

endmodule

`default_nettype wire

//--- design/icache_ctrl.sv
`default_nettype none

module icache_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            valid,
    input  logic [31:0]                     pc_in,
    input  logic [icache_pkg::COOKIE_W-1:0] cookie_in,
    icache_lookup_if.ctrl                   lk,
    output logic                            lookup_en,
    input  logic [1:0]                      victim_way,
    output logic                            touch,
    output logic [icache_pkg::INDEX_W-1:0]  touch_index,
    output logic [1:0]                      touch_way,
    input  logic                            fill_finish,
    input  logic [icache_pkg::LINE_W-1:0]   fill_line,
    output logic                            fill_we,
    output logic [1:0]                      fill_way,
    output logic [icache_pkg::INDEX_W-1:0]  fill_index,
    output logic [icache_pkg::TAG_W-1:0]    fill_tag,
    output logic                            r_req,
    input  logic                            r_rdy,
    output logic [31:0]                     r_addr,
    output logic                            r_data_ready,
    output logic                            data_valid,
    output logic [icache_pkg::FETCH_W-1:0]  r_data_cpu,
    output logic [31:0]                     pc_out,
    output logic [icache_pkg::COOKIE_W-1:0] cookie_out,
    output logic [icache_pkg::EXC_W-1:0]    exception
);

    logic [1:0]                         state_q;
    logic [1:0]                         state_d;
    logic [31:0]                        pc_q;       // request buffer
    logic [icache_pkg::COOKIE_W-1:0]    cookie_q;
    logic [1:0]                         victim_q;   // way chosen at miss time
    logic                               in_idle;
    logic                               misalign;
    logic                               hit_any;
    logic                               slot_hit;
    logic                               slot_miss;
    logic                               fill_done;
    logic [1:0]                         hit_way;
    logic [icache_pkg::OFFSET_W-4:0]    word_sel;   // pc[5:3]
    logic [icache_pkg::FETCH_W-1:0]     hit_word;
    logic [icache_pkg::FETCH_W-1:0]     fill_word;

    assign in_idle   = (state_q == icache_pkg::ST_IDLE);
    assign misalign  = (pc_q[1:0] != 2'b00);
    assign hit_any   = |lk.way_hit;
    assign slot_hit  = in_idle && lk.lookup_valid && (misalign || hit_any);   // answered now
    assign slot_miss = in_idle && lk.lookup_valid && !misalign && !hit_any;
    assign fill_done = (state_q == icache_pkg::ST_REFILL) && fill_finish;

    // a miss in stage 2 blocks the next request in the same cycle
    assign lookup_en = valid && in_idle && !slot_miss;

    always_comb begin
        hit_way = 2'd0;
        for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
            if (lk.way_hit[w]) begin
                hit_way = 2'(w);
            end
        end
    end

    assign word_sel  = pc_q[icache_pkg::OFFSET_W-1:3];
    assign hit_word  = lk.way_line[hit_way][word_sel * icache_pkg::FETCH_W +: icache_pkg::FETCH_W];
    assign fill_word = fill_line[word_sel * icache_pkg::FETCH_W +: icache_pkg::FETCH_W];

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::ST_IDLE:     if (slot_miss) state_d = icache_pkg::ST_MISS_REQ;
            icache_pkg::ST_MISS_REQ: if (r_rdy) state_d = icache_pkg::ST_REFILL;
            icache_pkg::ST_REFILL:   if (fill_finish) state_d = icache_pkg::ST_RESPOND;
            default:                 state_d = icache_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= icache_pkg::ST_IDLE;
            data_valid <= 1'b0;
        end else begin
            state_q    <= state_d;
            data_valid <= slot_hit || fill_done;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            pc_q     <= pc_in;
            cookie_q <= cookie_in;
        end
        if (slot_miss) begin
            victim_q <= victim_way;
        end
        if (fill_done) begin
            r_data_cpu <= fill_word;                // straight from the refill line
            pc_out     <= pc_q;
            cookie_out <= cookie_q;
            exception  <= icache_pkg::EXC_NONE;
        end else if (slot_hit) begin
            r_data_cpu <= misalign ? '0 : hit_word;
            pc_out     <= pc_q;
            cookie_out <= cookie_q;
            exception  <= misalign ? icache_pkg::EXC_FETCH_MISALIGN : icache_pkg::EXC_NONE;
        end
    end

    // line read request
    assign r_req        = (state_q == icache_pkg::ST_MISS_REQ);
    assign r_addr       = {pc_q[31:icache_pkg::OFFSET_W], {icache_pkg::OFFSET_W{1'b0}}};
    assign r_data_ready = (state_q == icache_pkg::ST_REFILL);

    // refill write into both arrays
    assign fill_we    = fill_done;
    assign fill_way   = victim_q;
    assign fill_index = pc_q[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
    assign fill_tag   = pc_q[icache_pkg::OFFSET_W + icache_pkg::INDEX_W +: icache_pkg::TAG_W];

    // lru update on real hits and on fills
    assign touch       = fill_done || (slot_hit && !misalign);
    assign touch_index = fill_index;
    assign touch_way   = fill_done ? victim_q : hit_way;

    // request and its line address stay put until the memory takes them
    a_req_held: assert property (@(posedge clk) disable iff (rst)
        (r_req && !r_rdy) |=> r_req && $stable(r_addr));

endmodule

`default_nettype wire

//--- design/icache_data_array.sv
`default_nettype none

module icache_data_array (
    input  logic                           clk,
    input  logic                           lookup_en,
    input  logic [31:0]                    pc_in,
    input  logic                           fill_we,
    input  logic [1:0]                     fill_way,
    input  logic [icache_pkg::INDEX_W-1:0] fill_index,
    input  logic [icache_pkg::LINE_W-1:0]  fill_line,
    icache_lookup_if.arr_data              lk
);

    logic [icache_pkg::LINE_W-1:0]  line_mem [icache_pkg::NUM_WAYS][icache_pkg::NUM_SETS];
    logic [icache_pkg::INDEX_W-1:0] rd_index;

    assign rd_index = pc_in[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];

    // whole line write, refill only
    always_ff @(posedge clk) begin
        if (fill_we) begin
            line_mem[fill_way][fill_index] <= fill_line;
        end
    end

    // all four ways read in parallel, held while lookup_en is low
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
                lk.way_line[w] <= line_mem[w][rd_index];
            end
        end
    end

endmodule

`default_nettype wire

//--- design/icache_lookup_if.sv
`default_nettype none

interface icache_lookup_if;

    logic [icache_pkg::NUM_WAYS-1:0]                         way_hit;       // one bit per way
    logic [icache_pkg::NUM_WAYS-1:0][icache_pkg::LINE_W-1:0] way_line;      // lines read out
    logic                                                    lookup_valid;  // stage 1 slot full

    // tag side drives hit info
    modport arr_tag (
        output way_hit,
        output lookup_valid
    );

    // data side drives the lines
    modport arr_data (
        output way_line
    );

    modport ctrl (
        input way_hit,
        input way_line,
        input lookup_valid
    );

endinterface

`default_nettype wire

//--- design/icache_lru.sv
`default_nettype none

module icache_lru (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           touch,
    input  logic [icache_pkg::INDEX_W-1:0] touch_index,
    input  logic [1:0]                     touch_way,
    output logic [1:0]                     victim_way
);

    logic [icache_pkg::NUM_WAYS-1:0][1:0] age_q [icache_pkg::NUM_SETS];   // 0 is newest

    function automatic logic ages_distinct(input logic [icache_pkg::NUM_WAYS-1:0][1:0] ages);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < icache_pkg::NUM_WAYS; i++) begin
            for (int j = i + 1; j < icache_pkg::NUM_WAYS; j++) begin
                if (ages[i] == ages[j]) begin
                    ok = 1'b0;
                end
            end
        end
        return ok;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < icache_pkg::NUM_SETS; s++) begin
                for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
                    age_q[s][w] <= 2'(w);               // way order
                end
            end
        end else if (touch) begin
            for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
                if (2'(w) == touch_way) begin
                    age_q[touch_index][w] <= 2'd0;
                end else if (age_q[touch_index][w] < age_q[touch_index][touch_way]) begin
                    age_q[touch_index][w] <= age_q[touch_index][w] + 2'd1;
                end
            end
        end
    end

    // oldest way of the set
    always_comb begin
        victim_way = 2'd0;
        for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
            if (age_q[touch_index][w] == 2'(icache_pkg::NUM_WAYS - 1)) begin
                victim_way = 2'(w);
            end
        end
    end

    a_ages_distinct: assert property (@(posedge clk) disable iff (rst)
        ages_distinct(age_q[touch_index]));

endmodule

`default_nettype wire

//--- design/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // request side
    localparam int COOKIE_W = 32;

    // geometry, 4 ways x 64 sets x 64 bytes
    localparam int NUM_WAYS = 4;
    localparam int NUM_SETS = 64;
    localparam int INDEX_W  = 6;                // pc[11:6]
    localparam int TAG_W    = 20;               // pc[31:12]
    localparam int OFFSET_W = 6;                // pc[5:0]
    localparam int LINE_W   = 512;

    // refill port
    localparam int BEATS  = 16;                 // beats per line
    localparam int BEAT_W = 32;

    // fetch word, two instructions
    localparam int FETCH_W = 64;

    // exception codes
    localparam int EXC_W = 7;
    localparam logic [EXC_W-1:0] EXC_NONE           = 7'h00;
    localparam logic [EXC_W-1:0] EXC_FETCH_MISALIGN = 7'h04;

    // stage 2 miss FSM encoding
    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_MISS_REQ = 2'd1;   // r_req up, waiting for r_rdy
    localparam logic [1:0] ST_REFILL   = 2'd2;   // collecting beats
    localparam logic [1:0] ST_RESPOND  = 2'd3;   // refill data on the outputs

endpackage

`default_nettype wire

//--- design/icache_refill_buf.sv
`default_nettype none

module icache_refill_buf (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          ret_valid,
    input  logic                          ret_last,
    input  logic [icache_pkg::BEAT_W-1:0] r_data_axi,
    output logic                          fill_finish,
    output logic [icache_pkg::LINE_W-1:0] fill_line
);

    logic [$clog2(icache_pkg::BEATS)-1:0] beat_cnt;

    // beats enter at the top, first beat ends up in bits [31:0]
    always_ff @(posedge clk) begin
        if (ret_valid) begin
            fill_line <= {r_data_axi, fill_line[icache_pkg::LINE_W-1:icache_pkg::BEAT_W]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_finish <= 1'b0;
            beat_cnt    <= '0;
        end else begin
            fill_finish <= ret_valid && ret_last;   // one cycle after last beat
            if (ret_valid) begin
                if (ret_last) begin
                    beat_cnt <= '0;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    // memory side must close the line on exactly the 16th beat
    a_last_on_final_beat: assert property (@(posedge clk) disable iff (rst)
        (ret_valid && ret_last) |-> (beat_cnt == icache_pkg::BEATS - 1));

    // and the 16th beat cannot go out without ret_last
    a_final_beat_is_last: assert property (@(posedge clk) disable iff (rst)
        (ret_valid && (beat_cnt == icache_pkg::BEATS - 1)) |-> ret_last);

endmodule

`default_nettype wire

//--- design/icache_tag_array.sv
`default_nettype none

module icache_tag_array (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           lookup_en,
    input  logic [31:0]                    pc_in,
    input  logic                           fill_we,
    input  logic [1:0]                     fill_way,
    input  logic [icache_pkg::INDEX_W-1:0] fill_index,
    input  logic [icache_pkg::TAG_W-1:0]   fill_tag,
    icache_lookup_if.arr_tag               lk
);

    logic [icache_pkg::TAG_W-1:0]    tag_mem [icache_pkg::NUM_WAYS][icache_pkg::NUM_SETS];
    logic [icache_pkg::NUM_SETS-1:0] valid_q [icache_pkg::NUM_WAYS];

    logic [icache_pkg::INDEX_W-1:0]  rd_index;
    logic [icache_pkg::TAG_W-1:0]    rd_tag [icache_pkg::NUM_WAYS];   // stored tags of the set
    logic [icache_pkg::NUM_WAYS-1:0] rd_valid;
    logic [icache_pkg::TAG_W-1:0]    req_tag_q;                       // tag of the request
    logic                            lookup_valid_q;

    assign rd_index = pc_in[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];

    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_mem[fill_way][fill_index] <= fill_tag;
        end
        if (lookup_en) begin
            for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
                rd_tag[w]   <= tag_mem[w][rd_index];
                rd_valid[w] <= valid_q[w][rd_index];
            end
            req_tag_q <= pc_in[icache_pkg::OFFSET_W + icache_pkg::INDEX_W +: icache_pkg::TAG_W];
        end
    end

    // valid bits and slot flag are the only state with reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
                valid_q[w] <= '0;
            end
            lookup_valid_q <= 1'b0;
        end else begin
            if (fill_we) begin
                valid_q[fill_way][fill_index] <= 1'b1;
            end
            lookup_valid_q <= lookup_en;
        end
    end

    always_comb begin
        for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
            lk.way_hit[w] = lookup_valid_q && rd_valid[w] && (rd_tag[w] == req_tag_q);
        end
    end

    assign lk.lookup_valid = lookup_valid_q;

    // a line is only ever filled into one way, so no double hits
    a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(lk.way_hit));

endmodule

`default_nettype wire

//--- sim/axi_line_mem.sv
`default_nettype none

module axi_line_mem (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall_en,       // random r_rdy delay and beat gaps
    input  logic        r_req,
    input  logic [31:0] r_addr,
    input  logic        r_data_ready,
    output logic        r_rdy,
    output logic        ret_valid,
    output logic        ret_last,
    output logic [31:0] r_data_axi
);

    integer      seed = 32'h7585_8def;
    logic        busy;                  // line accepted, beats still to send
    logic [3:0]  beat;
    logic [2:0]  wait_cnt;              // cycles left before r_rdy
    logic [31:0] line_addr;

    initial begin
        r_rdy      = 1'b0;
        ret_valid  = 1'b0;
        ret_last   = 1'b0;
        r_data_axi = '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            r_rdy     <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            busy      <= 1'b0;
            beat      <= '0;
            wait_cnt  <= '0;
        end else begin
            r_rdy     <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            if (!busy && r_req && !r_rdy) begin
                if (wait_cnt == 3'd0) begin
                    r_rdy     <= 1'b1;
                    busy      <= 1'b1;
                    beat      <= '0;
                    line_addr <= r_addr;
                    wait_cnt  <= stall_en ? 3'($random(seed)) : 3'd0;   // delay of the next one
                end else begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
            end else if (busy && r_data_ready) begin
                // about one gap in four beats
                if (!stall_en || ($random(seed) & 3) != 0) begin
                    ret_valid  <= 1'b1;
                    ret_last   <= (beat == 4'd15);
                    r_data_axi <= ((line_addr >> 2) + 32'(beat)) ^ 32'hA5A5_0000;
                    beat       <= beat + 1'b1;
                    busy       <= (beat != 4'd15);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/icache_tb.sv
`default_nettype none

module icache_tb;

    logic                            clk;
    logic                            rst;
    logic                            valid;
    logic [31:0]                     pc_in;
    logic [icache_pkg::COOKIE_W-1:0] cookie_in;
    logic                            data_valid;
    logic [icache_pkg::FETCH_W-1:0]  r_data_cpu;
    logic [31:0]                     pc_out;
    logic [icache_pkg::COOKIE_W-1:0] cookie_out;
    logic [icache_pkg::EXC_W-1:0]    exception;
    logic                            r_req;
    logic                            r_data_ready;
    logic [31:0]                     r_addr;
    logic                            r_rdy;
    logic                            ret_valid;
    logic                            ret_last;
    logic [31:0]                     r_data_axi;
    logic                            stall_en;

    logic [31:0]                     exp_fifo [16];   // requests in issue order
    logic [3:0]                      wr_ptr;
    logic [3:0]                      rd_ptr;
    logic [31:0]                     exp_pc;
    logic [icache_pkg::FETCH_W-1:0]  exp_data;
    logic [icache_pkg::EXC_W-1:0]    exp_exc;
    logic                            expect_fast;     // request should answer with hit timing
    logic                            no_miss_phase;
    string                           test_name;
    int                              err_count;
    int                              err_at_start;
    int                              test_count;
    int                              failed_tests;

    icache dut0 (.*);

    axi_line_mem mem0 (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // two model words, low half at the lower address
    function automatic logic [63:0] model_word(input logic [31:0] pc);
        logic [31:0] wa;
        wa = {2'b00, pc[31:3], 1'b0};
        return {(wa + 32'd1) ^ 32'hA5A5_0000, wa ^ 32'hA5A5_0000};
    endfunction

    function automatic logic [31:0] make_pc(input logic [icache_pkg::TAG_W-1:0] tag,
                                            input logic [icache_pkg::INDEX_W-1:0] index,
                                            input logic [5:0] offset);
        return {tag, index, offset};
    endfunction

    assign exp_pc   = exp_fifo[rd_ptr];
    assign exp_data = (exp_pc[1:0] != 2'b00) ? '0 : model_word(exp_pc);
    assign exp_exc  = (exp_pc[1:0] != 2'b00) ? icache_pkg::EXC_FETCH_MISALIGN
                                             : icache_pkg::EXC_NONE;

    always @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (data_valid) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    a_data: assert property (@(posedge clk) disable iff (rst)
        data_valid |-> r_data_cpu == exp_data)
        else begin
            err_count++;
            $display("error %s r_data_cpu expected %h actual %h", test_name,
                     $sampled(exp_data), $sampled(r_data_cpu));
        end

    // pc_out and cookie_out together
    a_echo: assert property (@(posedge clk) disable iff (rst)
        data_valid |-> {pc_out, cookie_out} == {exp_pc, ~exp_pc})
        else begin
            err_count++;
            $display("error %s pc and cookie expected %h actual %h", test_name,
                     $sampled({exp_pc, ~exp_pc}), $sampled({pc_out, cookie_out}));
        end

    a_exc: assert property (@(posedge clk) disable iff (rst)
        data_valid |-> exception == exp_exc)
        else begin
            err_count++;
            $display("error %s exception expected %h actual %h", test_name,
                     $sampled(exp_exc), $sampled(exception));
        end

    a_fast: assert property (@(posedge clk) disable iff (rst)
        (valid && expect_fast) |-> ##2 data_valid)
        else begin
            err_count++;
            $display("%s: no data_valid one cycle after a hit was accepted", test_name);
        end

    a_no_req: assert property (@(posedge clk) disable iff (rst)
        no_miss_phase |-> !r_req)
        else begin
            err_count++;
            $display("%s: r_req raised while only hits were expected", test_name);
        end

    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        (r_req && !r_rdy) |=> r_req)
        else begin
            err_count++;
            $display("%s: r_req dropped before r_rdy", test_name);
        end

    a_addr: assert property (@(posedge clk) disable iff (rst)
        r_req |-> r_addr == {exp_pc[31:6], 6'b0})
        else begin
            err_count++;
            $display("error %s r_addr expected %h actual %h", test_name,
                     $sampled({exp_pc[31:6], 6'b0}), $sampled(r_addr));
        end

    // beats are taken once the line read is accepted
    a_ready_up: assert property (@(posedge clk) disable iff (rst)
        (r_req && r_rdy) |=> r_data_ready)
        else begin
            err_count++;
            $display("%s: r_data_ready not raised after r_rdy", test_name);
        end

    a_ready_low: assert property (@(posedge clk) disable iff (rst)
        (r_req || data_valid) |-> !r_data_ready)
        else begin
            err_count++;
            $display("%s: r_data_ready high outside a refill", test_name);
        end

    task automatic drive_request(input logic [31:0] pc);
        exp_fifo[wr_ptr] <= pc;
        wr_ptr           <= wr_ptr + 1'b1;
        valid            <= 1'b1;
        pc_in            <= pc;
        cookie_in        <= ~pc;
    endtask

    // requests on consecutive cycles, all answered without a line read
    task automatic fetch_burst(input logic [31:0] first_pc, input int count, input int stride);
        int n;
        for (int k = 0; k < count; k++) begin
            @(posedge clk);
            drive_request(first_pc + 32'(k * stride));
            expect_fast   <= 1'b1;
            no_miss_phase <= 1'b1;
        end
        @(posedge clk);
        valid       <= 1'b0;
        expect_fast <= 1'b0;
        n = 0;
        while (rd_ptr != wr_ptr && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (rd_ptr != wr_ptr) begin
            err_count++;
            $display("%s: timeout, responses to a burst are missing", test_name);
        end
        no_miss_phase <= 1'b0;
    endtask

    // valid is held until the refilled word comes back
    task automatic fetch_miss(input logic [31:0] pc);
        int n;
        bit got_req;
        bit done;
        n       = 0;
        got_req = 1'b0;
        done    = 1'b0;
        @(posedge clk);
        drive_request(pc);
        while (!done && n < 400) begin
            @(posedge clk);
            n++;
            if (r_req) begin
                got_req = 1'b1;
            end
            if (data_valid) begin
                done = 1'b1;
            end
        end
        valid <= 1'b0;
        if (!done) begin
            err_count++;
            $display("%s: timeout waiting for the refill of pc %h", test_name, pc);
        end else if (!got_req) begin
            err_count++;
            $display("%s: pc %h returned without a line read", test_name, pc);
        end
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        err_at_start = err_count;
    endtask

    task automatic finish_test();
        test_count++;
        if (err_count == err_at_start) begin
            $display("test %s done, ok", test_name);
        end else begin
            failed_tests++;
            $display("test %s done, %0d errors", test_name, err_count - err_at_start);
        end
    endtask

    initial begin
        rst           = 1'b1;
        valid         = 1'b0;
        pc_in         = '0;
        cookie_in     = '0;
        stall_en      = 1'b0;
        wr_ptr        = '0;
        expect_fast   = 1'b0;
        no_miss_phase = 1'b0;
        test_name     = "reset";
        err_count     = 0;
        err_at_start  = 0;
        test_count    = 0;
        failed_tests  = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        begin_test("cold_miss");
        for (int i = 0; i < 4; i++) begin
            fetch_miss(make_pc(20'(32'h100 + i), 6'(i), 6'(i * 8 + 4)));
        end
        finish_test();

        begin_test("hit");
        for (int i = 0; i < 4; i++) begin
            fetch_burst(make_pc(20'(32'h100 + i), 6'(i), 6'd0), 8, 8);   // every word
        end
        finish_test();

        begin_test("lru");
        for (int i = 0; i < 4; i++) begin
            fetch_miss(make_pc(20'(32'h200 + i), 6'd20, 6'd0));          // lines a to d
        end
        fetch_burst(make_pc(20'h200, 6'd20, 6'd8), 1, 8);               // touch a
        fetch_miss(make_pc(20'h204, 6'd20, 6'd16));                      // e replaces b
        fetch_burst(make_pc(20'h200, 6'd20, 6'd24), 1, 8);
        fetch_miss(make_pc(20'h201, 6'd20, 6'd32));
        finish_test();

        begin_test("backpressure");
        @(posedge clk);
        stall_en <= 1'b1;
        for (int i = 0; i < 6; i++) begin
            fetch_miss(make_pc(20'(32'h300 + i), 6'(32 + i), 6'(i * 4)));
        end
        @(posedge clk);
        stall_en <= 1'b0;
        fetch_burst(make_pc(20'h305, 6'd37, 6'd0), 8, 8);
        finish_test();

        begin_test("misalign");
        fetch_burst(make_pc(20'h100, 6'd0, 6'd1), 3, 1);     // line already present
        fetch_burst(make_pc(20'h3ff, 6'd50, 6'd2), 2, 1);    // line never filled
        finish_test();

        $display("%0d tests run, %0d failed, %0d errors", test_count, failed_tests, err_count);
        if (err_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
